// File: rtl/vec_pkg.sv
// Fixed 32-bit elements and 8 registers; VlMax and NrLanes must be powers of two, VlMax >= NrLanes
`default_nettype none

package vec_pkg;

  //////////////////////////////
  // Machine sizes
  //////////////////////////////

  localparam int unsigned NrLanes     = 4;
  localparam int unsigned ElemWidth   = 32;
  localparam int unsigned NrVRegs     = 8;
  localparam int unsigned VlMax       = 8;
  localparam int unsigned RowsPerLane = VlMax / NrLanes;
  localparam int unsigned QueueDepth  = 4;

  // Index widths, kept at least one bit wide
  localparam int unsigned LaneIdxWidth = (NrLanes > 1) ? $clog2(NrLanes) : 1;
  localparam int unsigned RowIdxWidth  = (RowsPerLane > 1) ? $clog2(RowsPerLane) : 1;

  typedef logic [ElemWidth-1:0]   elem_t;
  typedef logic [2:0]             vreg_idx_t;
  typedef logic [3:0]             vl_t;
  typedef logic [RowIdxWidth-1:0] row_idx_t;
  // Row count per lane, holds 0 to RowsPerLane
  typedef logic [RowIdxWidth:0]   row_cnt_t;

  //////////////////////////////
  // Instructions
  //////////////////////////////

  typedef enum logic [2:0] {
    OP_VADD_VV  = 3'd0,
    OP_VSUB_VV  = 3'd1,
    OP_VAND_VV  = 3'd2,
    OP_VOR_VV   = 3'd3,
    OP_VXOR_VV  = 3'd4,
    OP_VADD_VX  = 3'd5,
    OP_VMV_VX   = 3'd6,
    OP_VEXTRACT = 3'd7
  } vec_op_e;

  // For OP_VEXTRACT the scalar field carries the element index
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    vl_t       vl;
  } vec_req_t;

  typedef struct packed {
    elem_t data;
  } vec_resp_t;

endpackage : vec_pkg

`default_nettype wire

// File: rtl/vec_lane_if.sv
// Instruction fields must stay stable from the issue pulse until every lane has pulsed done
`timescale 1ns/1ps
`default_nettype none

interface vec_lane_if import vec_pkg::*; ();

  // Broadcast from the sequencer
  logic      issue;
  vec_op_e   op;
  vreg_idx_t vd;
  vreg_idx_t vs1;
  vreg_idx_t vs2;
  elem_t     scalar;
  vl_t       vl;

  // One entry per lane, each lane drives only its own
  logic  [NrLanes-1:0] done;
  elem_t [NrLanes-1:0] rdata;

  modport seq (
    output issue,
    output op,
    output vd,
    output vs1,
    output vs2,
    output scalar,
    output vl,
    input  done,
    input  rdata
  );

  modport lane (
    input  issue,
    input  op,
    input  vd,
    input  vs1,
    input  vs2,
    input  scalar,
    input  vl,
    output done,
    output rdata
  );

endinterface : vec_lane_if

`default_nettype wire

// File: rtl/vec_fifo.sv
// Show-ahead FIFO, no bypass; pushing while full or popping while empty is illegal
`timescale 1ns/1ps
`default_nettype none

module vec_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 4
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     push_i,
  input  payload_t push_data_i,
  input  logic     pop_i,
  output logic     full_o,
  output logic     empty_o,
  output payload_t pop_data_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t [Depth-1:0] mem_q;
  logic [PtrWidth-1:0]  wr_ptr_q;
  logic [PtrWidth-1:0]  rd_ptr_q;
  logic [CntWidth-1:0]  count_q;

  assign full_o     = (count_q == CntWidth'(Depth));
  assign empty_o    = (count_q == '0);
  assign pop_data_o = mem_q[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap at Depth
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_no_overflow_underflow : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !(push_i && full_o) && !(pop_i && empty_o)
  );

endmodule : vec_fifo

`default_nettype wire

// File: rtl/vec_dispatcher.sv
// Clamps vl to VlMax on entry; no decode checks, every request is taken as given
`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Host side
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  vec_req_t  req_i,
  output logic      resp_valid_o,
  input  logic      resp_ready_i,
  output vec_resp_t resp_o,
  // Sequencer side
  output logic      seq_req_valid_o,
  input  logic      seq_req_ready_i,
  output vec_req_t  seq_req_o,
  input  logic      seq_resp_valid_i,
  output logic      seq_resp_ready_o,
  input  vec_resp_t seq_resp_i
);

  vec_req_t req_clamped;
  logic     ready_en_q;
  logic     insn_full;
  logic     insn_empty;
  logic     resp_full;
  logic     resp_empty;

  // Host ready stays low until the first edge after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_en_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
    end
  end

  always_comb begin
    req_clamped = req_i;
    if (req_i.vl > vl_t'(VlMax)) begin
      req_clamped.vl = vl_t'(VlMax);
    end
  end

  assign req_ready_o = ready_en_q & ~insn_full;

  //////////////////////////////
  // Instruction queue
  //////////////////////////////

  vec_fifo #(
    .payload_t(vec_req_t ),
    .Depth    (QueueDepth)
  ) i_insn_queue (
    .clk_i      (clk_i                          ),
    .arst_n_i   (arst_n_i                       ),
    .push_i     (req_valid_i & req_ready_o      ),
    .push_data_i(req_clamped                    ),
    .pop_i      (seq_req_valid_o & seq_req_ready_i),
    .full_o     (insn_full                      ),
    .empty_o    (insn_empty                     ),
    .pop_data_o (seq_req_o                      )
  );

  assign seq_req_valid_o = ~insn_empty;

  //////////////////////////////
  // Response queue
  //////////////////////////////

  vec_fifo #(
    .payload_t(vec_resp_t),
    .Depth    (QueueDepth)
  ) i_resp_queue (
    .clk_i      (clk_i                              ),
    .arst_n_i   (arst_n_i                           ),
    .push_i     (seq_resp_valid_i & seq_resp_ready_o),
    .push_data_i(seq_resp_i                         ),
    .pop_i      (resp_valid_o & resp_ready_i        ),
    .full_o     (resp_full                          ),
    .empty_o    (resp_empty                         ),
    .pop_data_o (resp_o                             )
  );

  assign seq_resp_ready_o = ~resp_full;
  assign resp_valid_o     = ~resp_empty;

endmodule : vec_dispatcher

`default_nettype wire

// File: rtl/vec_sequencer.sv
// One instruction in flight at a time; a pop needs room in the response queue first
`timescale 1ns/1ps
`default_nettype none

module vec_sequencer import vec_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  // Dispatcher side
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  vec_req_t   req_i,
  output logic       resp_valid_o,
  input  logic       resp_ready_i,
  output vec_resp_t  resp_o,
  // Lanes
  vec_lane_if.seq    lane_if
);

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_WAIT
  } seq_state_e;

  seq_state_e          state_q;
  vec_req_t            insn_q;
  logic [NrLanes-1:0]  pending_q;
  logic [LaneIdxWidth-1:0] src_lane;

  // Pop only when idle and the response has somewhere to go
  assign req_ready_o  = (state_q == SEQ_IDLE) & resp_ready_i;
  // All lanes reported in an earlier cycle
  assign resp_valid_o = (state_q == SEQ_WAIT) & (pending_q == '0);

  //////////////////////////////
  // Broadcast
  //////////////////////////////

  assign lane_if.issue  = (state_q == SEQ_ISSUE);
  assign lane_if.op     = insn_q.op;
  assign lane_if.vd     = insn_q.vd;
  assign lane_if.vs1    = insn_q.vs1;
  assign lane_if.vs2    = insn_q.vs2;
  assign lane_if.scalar = insn_q.scalar;
  assign lane_if.vl     = insn_q.vl;

  // Element k sits in lane k mod NrLanes
  assign src_lane = insn_q.scalar[LaneIdxWidth-1:0];

  always_comb begin
    resp_o.data = '0;
    if (insn_q.op == OP_VEXTRACT) begin
      resp_o.data = lane_if.rdata[src_lane];
    end
  end

  // Instruction register, held until the response is pushed
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      insn_q <= req_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= SEQ_IDLE;
      pending_q <= '0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          if (req_valid_i && req_ready_o) begin
            state_q <= SEQ_ISSUE;
          end
        end
        SEQ_ISSUE: begin
          pending_q <= '1;
          state_q   <= SEQ_WAIT;
        end
        SEQ_WAIT: begin
          pending_q <= pending_q & ~lane_if.done;
          // Response leaves this cycle
          if (pending_q == '0) begin
            state_q <= SEQ_IDLE;
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  // Lanes only answer an issued instruction
  a_no_done_when_idle : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (state_q == SEQ_IDLE) |-> (lane_if.done == '0)
  );

endmodule : vec_sequencer

`default_nettype wire

// File: rtl/vec_lane.sv
// Element i lives at row i/NrLanes of lane i mod NrLanes; sub computes vs2 minus vs1
`timescale 1ns/1ps
`default_nettype none

module vec_lane import vec_pkg::*; #(
  parameter int unsigned LaneId = 0
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  vec_lane_if.lane lane_if
);

  elem_t [NrVRegs-1:0][RowsPerLane-1:0] rf_q;

  logic     busy_q;
  logic     done_q;
  row_idx_t row_q;
  row_cnt_t elem_cnt;
  logic     last_row;
  row_idx_t rd_row;
  elem_t    op_a;
  elem_t    op_b;
  elem_t    alu_res;

  //////////////////////////////
  // Element count
  //////////////////////////////

  // Indices below vl that map onto this lane
  always_comb begin
    elem_cnt = '0;
    if (lane_if.vl > vl_t'(LaneId)) begin
      elem_cnt = row_cnt_t'((lane_if.vl - vl_t'(LaneId) - vl_t'(1)) / vl_t'(NrLanes)
                            + vl_t'(1));
    end
  end

  assign last_row = (row_cnt_t'(row_q) + row_cnt_t'(1)) == elem_cnt;

  // Extract read port, element index in scalar
  assign rd_row                 = lane_if.scalar[LaneIdxWidth +: RowIdxWidth];
  assign lane_if.rdata[LaneId]  = rf_q[lane_if.vs2][rd_row];
  assign lane_if.done[LaneId]   = done_q;

  //////////////////////////////
  // Integer ALU
  //////////////////////////////

  always_comb begin
    op_a = rf_q[lane_if.vs2][row_q];
    op_b = rf_q[lane_if.vs1][row_q];
    case (lane_if.op)
      OP_VADD_VV: alu_res = op_a + op_b;
      OP_VSUB_VV: alu_res = op_a - op_b;
      OP_VAND_VV: alu_res = op_a & op_b;
      OP_VOR_VV:  alu_res = op_a | op_b;
      OP_VXOR_VV: alu_res = op_a ^ op_b;
      OP_VADD_VX: alu_res = op_a + lane_if.scalar;
      OP_VMV_VX:  alu_res = lane_if.scalar;
      // Extract never writes back
      default:    alu_res = '0;
    endcase
  end

  // One row per busy cycle, tail rows untouched
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rf_q <= '0;
    end else if (busy_q) begin
      rf_q[lane_if.vd][row_q] <= alu_res;
    end
  end

  //////////////////////////////
  // Element loop control
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      row_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (lane_if.issue) begin
        row_q <= '0;
        // Nothing to write here, answer right away
        if (lane_if.op == OP_VEXTRACT || elem_cnt == '0) begin
          done_q <= 1'b1;
        end else begin
          busy_q <= 1'b1;
        end
      end else if (busy_q) begin
        row_q <= row_q + 1'b1;
        if (last_row) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Sequencer waits for every lane before the next issue
  a_no_issue_when_busy : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    lane_if.issue |-> !(busy_q || done_q)
  );

endmodule : vec_lane

`default_nettype wire

// File: rtl/vec_top.sv
// Instructions run strictly in order, one response each; resp_data_o is zero except for extract
`timescale 1ns/1ps
`default_nettype none

module vec_top import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Request port
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  vec_op_e   req_op_i,
  input  vreg_idx_t req_vd_i,
  input  vreg_idx_t req_vs1_i,
  input  vreg_idx_t req_vs2_i,
  input  elem_t     req_scalar_i,
  input  vl_t       req_vl_i,
  // Response port
  output logic      resp_valid_o,
  input  logic      resp_ready_i,
  output elem_t     resp_data_o
);

  vec_req_t  host_req;
  vec_resp_t host_resp;
  vec_req_t  seq_req;
  logic      seq_req_valid;
  logic      seq_req_ready;
  vec_resp_t seq_resp;
  logic      seq_resp_valid;
  logic      seq_resp_ready;

  assign host_req = '{
    op:     req_op_i,
    vd:     req_vd_i,
    vs1:    req_vs1_i,
    vs2:    req_vs2_i,
    scalar: req_scalar_i,
    vl:     req_vl_i
  };

  assign resp_data_o = host_resp.data;

  vec_dispatcher i_dispatcher (
    .clk_i           (clk_i         ),
    .arst_n_i        (arst_n_i      ),
    .req_valid_i     (req_valid_i   ),
    .req_ready_o     (req_ready_o   ),
    .req_i           (host_req      ),
    .resp_valid_o    (resp_valid_o  ),
    .resp_ready_i    (resp_ready_i  ),
    .resp_o          (host_resp     ),
    .seq_req_valid_o (seq_req_valid ),
    .seq_req_ready_i (seq_req_ready ),
    .seq_req_o       (seq_req       ),
    .seq_resp_valid_i(seq_resp_valid),
    .seq_resp_ready_o(seq_resp_ready),
    .seq_resp_i      (seq_resp      )
  );

  vec_lane_if lane_bus ();

  vec_sequencer i_sequencer (
    .clk_i       (clk_i         ),
    .arst_n_i    (arst_n_i      ),
    .req_valid_i (seq_req_valid ),
    .req_ready_o (seq_req_ready ),
    .req_i       (seq_req       ),
    .resp_valid_o(seq_resp_valid),
    .resp_ready_i(seq_resp_ready),
    .resp_o      (seq_resp      ),
    .lane_if     (lane_bus.seq  )
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .LaneId(l)
    ) i_lane (
      .clk_i   (clk_i        ),
      .arst_n_i(arst_n_i     ),
      .lane_if (lane_bus.lane)
    );
  end : gen_lanes

endmodule : vec_top

`default_nettype wire

// File: tb/tb_vec_top.sv
// Run from the project root so tb/vec_vectors.txt resolves; expected data assumes a zeroed register file
`timescale 1ns/1ps
`default_nettype none

module tb_vec_top import vec_pkg::*; ();

  localparam int unsigned ClkPeriod         = 40;
  localparam int unsigned ResetCycles       = 8;
  localparam int unsigned CyclesPerVector   = 40;
  localparam int unsigned DrainCycles       = 40;
  localparam string       VectorFile        = "tb/vec_vectors.txt";

  logic      clk_i = 1'b0;
  logic      arst_n_i;
  logic      req_valid_i;
  logic      req_ready_o;
  vec_op_e   req_op_i;
  vreg_idx_t req_vd_i;
  vreg_idx_t req_vs1_i;
  vreg_idx_t req_vs2_i;
  elem_t     req_scalar_i;
  vl_t       req_vl_i;
  logic      resp_valid_o;
  logic      resp_ready_i;
  elem_t     resp_data_o;

  vec_req_t    stim_q[$];
  elem_t       exp_q[$];
  int unsigned num_vecs       = 0;
  int unsigned resp_count     = 0;
  bit          vectors_loaded = 1'b0;
  integer      seed           = 32'h8548a708;
  integer      rnd;

  vec_top dut_i (
    .clk_i       (clk_i       ),
    .arst_n_i    (arst_n_i    ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .req_op_i    (req_op_i    ),
    .req_vd_i    (req_vd_i    ),
    .req_vs1_i   (req_vs1_i   ),
    .req_vs2_i   (req_vs2_i   ),
    .req_scalar_i(req_scalar_i),
    .req_vl_i    (req_vl_i    ),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i),
    .resp_data_o (resp_data_o )
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_resp(input string name, input elem_t expected, input elem_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
    end
  endtask

  // Columns are op vd vs1 vs2 scalar vl expected, all hex, # starts a comment
  task automatic load_vectors();
    integer      fd;
    integer      n;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_vd;
    logic [31:0] f_vs1;
    logic [31:0] f_vs2;
    logic [31:0] f_scalar;
    logic [31:0] f_vl;
    logic [31:0] f_exp;
    vec_req_t    req;
    fd = $fopen(VectorFile, "r");
    if (fd == 0) begin
      abort_run($sformatf("could not open vector file %s", VectorFile));
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h",
                    f_op, f_vd, f_vs1, f_vs2, f_scalar, f_vl, f_exp);
        if (n == 7) begin
          req.op     = vec_op_e'(f_op[2:0]);
          req.vd     = f_vd[2:0];
          req.vs1    = f_vs1[2:0];
          req.vs2    = f_vs2[2:0];
          req.scalar = f_scalar;
          req.vl     = f_vl[3:0];
          stim_q.push_back(req);
          exp_q.push_back(f_exp);
        end else if (n > 0) begin
          abort_run($sformatf("malformed vector line: %s", line));
        end
      end
    end
    $fclose(fd);
    num_vecs = stim_q.size();
  endtask

  // Called right after a rising edge, returns on the accepting edge
  task automatic send_req(input vec_req_t req);
    req_valid_i  <= 1'b1;
    req_op_i     <= req.op;
    req_vd_i     <= req.vd;
    req_vs1_i    <= req.vs1;
    req_vs2_i    <= req.vs2;
    req_scalar_i <= req.scalar;
    req_vl_i     <= req.vl;
    @(negedge clk_i);
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Random back-pressure on the response port
  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      resp_ready_i <= 1'b0;
    end else begin
      rnd = $random(seed);
      resp_ready_i <= rnd[0];
    end
  end

  initial begin : main
    arst_n_i     = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = OP_VADD_VV;
    req_vd_i     = '0;
    req_vs1_i    = '0;
    req_vs2_i    = '0;
    req_scalar_i = '0;
    req_vl_i     = '0;
    resp_ready_i = 1'b0;
    load_vectors();
    if (num_vecs == 0) begin
      abort_run("vector file holds no instructions");
    end
    vectors_loaded = 1'b1;
    repeat (ResetCycles - 1) @(posedge clk_i);
    // Both handshake outputs stay low while reset is held
    @(negedge clk_i);
    check_flag("reset req_ready_o", 1'b0, req_ready_o);
    check_flag("reset resp_valid_o", 1'b0, resp_valid_o);
    @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    foreach (stim_q[i]) begin
      send_req(stim_q[i]);
    end
    req_valid_i <= 1'b0;
    wait (resp_count == num_vecs);
    // Extra responses would show up here
    repeat (DrainCycles) @(posedge clk_i);
    $display("=== PASS ===");
    $finish;
  end

  //////////////////////////////
  // Response monitor
  //////////////////////////////

  initial begin : monitor
    vec_op_e op;
    wait (vectors_loaded);
    forever begin
      @(negedge clk_i);
      if (arst_n_i && resp_valid_o && resp_ready_i) begin
        if (resp_count >= num_vecs) begin
          abort_run("response arrived with no instruction outstanding");
        end
        op = stim_q[resp_count].op;
        check_resp($sformatf("vector %0d %s", resp_count, op.name()),
                   exp_q[resp_count], resp_data_o);
        resp_count++;
      end
    end
  end

  initial begin : watchdog
    longint unsigned limit_cycles;
    wait (vectors_loaded);
    limit_cycles = longint'(num_vecs) * CyclesPerVector + ResetCycles + DrainCycles;
    #(limit_cycles * ClkPeriod);
    abort_run($sformatf("timeout after %0d cycles with %0d of %0d responses",
                        limit_cycles, resp_count, num_vecs));
  end

endmodule : tb_vec_top

`default_nettype wire

// File: tb/vec_vectors.txt
# op vd vs1 vs2 scalar vl expected (hex); extract reads vs2 at index scalar
# ops 0 add 1 sub 2 and 3 or 4 xor 5 add.vx 6 splat 7 extract
6 1 0 0 fffffff0 8 00000000
6 2 0 0 0000002a 8 00000000
7 0 0 1 00000000 8 fffffff0
7 0 0 1 00000001 8 fffffff0
7 0 0 1 00000002 8 fffffff0
7 0 0 1 00000003 8 fffffff0
7 0 0 1 00000004 8 fffffff0
7 0 0 1 00000005 8 fffffff0
7 0 0 1 00000006 8 fffffff0
7 0 0 1 00000007 8 fffffff0
0 3 1 2 00000000 8 00000000
7 0 0 3 00000002 8 0000001a
7 0 0 3 00000007 8 0000001a
1 4 1 2 00000000 8 00000000
7 0 0 4 00000001 8 0000003a
7 0 0 4 00000006 8 0000003a
2 5 1 2 00000000 8 00000000
7 0 0 5 00000003 8 00000020
3 6 1 2 00000000 8 00000000
7 0 0 6 00000004 8 fffffffa
4 6 1 2 00000000 8 00000000
7 0 0 6 00000005 8 ffffffda
5 7 0 1 00000100 8 00000000
7 0 0 7 00000000 8 000000f0
7 0 0 7 00000007 8 000000f0
6 1 0 0 12345678 3 00000000
7 0 0 1 00000002 8 12345678
7 0 0 1 00000003 8 fffffff0
7 0 0 1 00000007 8 fffffff0
6 5 0 0 0badf00d c 00000000
7 0 0 5 00000000 8 0badf00d
7 0 0 5 00000007 8 0badf00d

// File: vlog.f
rtl/vec_pkg.sv
rtl/vec_lane_if.sv
rtl/vec_fifo.sv
rtl/vec_dispatcher.sv
rtl/vec_sequencer.sv
rtl/vec_lane.sv
rtl/vec_top.sv
tb/tb_vec_top.sv

// File: Bender.yml
package:
  name: vec_coproc

sources:
  - files:
      - rtl/vec_pkg.sv
      - rtl/vec_lane_if.sv
      - rtl/vec_fifo.sv
      - rtl/vec_dispatcher.sv
      - rtl/vec_sequencer.sv
      - rtl/vec_lane.sv
      - rtl/vec_top.sv
  - target: test
    files:
      - tb/tb_vec_top.sv
